// ==== Bender.yml ====
package:
  name: frep_sequencer

export_include_dirs:
  - hw

sources:
  - hw/frep_pkg.sv
  - hw/frep_buf_if.sv
  - hw/frep_seq_if.sv
  - hw/frep_dispatch.sv
  - hw/frep_ring_buffer.sv
  - hw/frep_loop_ctrl.sv
  - hw/frep_issue.sv
  - hw/frep_sequencer.sv
  - target: test
    files:
      - verification/frep_sequencer_tb.sv

// ==== hw/frep_buf_if.sv ====
// Ring buffer link
// Write port from dispatch, read and release port from the loop controller
`timescale 1ns/1ps
`default_nettype none
`include "frep_macros.svh"

interface frep_buf_if;

  // Write side, transfer on wvalid and wready
  logic                       wvalid;
  logic                       wready;
  frep_pkg::buf_entry_t       wdata;
  logic [`FREP_PTR_WIDTH-1:0] wptr;

  // Random read and release
  logic [`FREP_PTR_WIDTH-1:0] raddr;
  logic                       advance;
  logic [`FREP_PTR_WIDTH:0]   step;
  frep_pkg::buf_entry_t       rdata;
  logic                       avail;
  logic                       empty;

  modport wr_src (output wvalid, wdata, input wready);
  modport wr_dst (input wvalid, wdata, output wready, wptr);
  modport rd_ctrl (output raddr, advance, step, input rdata, avail, empty, wptr);
  modport rd_mem (input raddr, advance, step, output rdata, avail, empty);

endinterface

`default_nettype wire

// ==== hw/frep_dispatch.sv ====
// FREP dispatch
// Sorts each input word onto the buffer, direct or FREP path
`timescale 1ns/1ps
`default_nettype none
`include "frep_macros.svh"

module frep_dispatch (
  input  frep_pkg::insn_u             inp_op_i,
  input  logic [`FREP_DATA_WIDTH-1:0] inp_arga_i,
  input  logic [`FREP_DATA_WIDTH-1:0] inp_argb_i,
  input  logic                        inp_valid_i,
  output logic                        inp_ready_o,
  frep_buf_if.wr_src                  buf_wr,
  output logic                        cfg_valid_o,
  output frep_pkg::insn_u             cfg_word_o,
  output logic [`FREP_ITER_WIDTH-1:0] cfg_iter_o,
  input  logic                        cfg_ready_i,
  output logic                        dir_valid_o,
  output frep_pkg::buf_entry_t        dir_entry_o,
  input  logic                        dir_ready_i
);

  frep_pkg::inst_path_e path_sel;
  frep_pkg::buf_entry_t entry;

  ////////////////////
  // Decoder
  ////////////////////

  always_comb begin : proc_decode
    path_sel = frep_pkg::PathBuffer;
    casez ({inp_op_i.regs.rs3, inp_op_i.regs.opcode})
      {5'b?????, `FREP_OPC_FREP}: begin
        path_sel = frep_pkg::PathFrep;
      end
      // CSR accesses and int/float crossings skip the buffer
      {5'b?????, `FREP_OPC_SYSTEM},
      {`FREP_F5_CMP, `FREP_OPC_OPFP},
      {`FREP_F5_CVT_TO_INT, `FREP_OPC_OPFP},
      {`FREP_F5_CVT_FROM_INT, `FREP_OPC_OPFP},
      {`FREP_F5_MV_TO_INT, `FREP_OPC_OPFP},
      {`FREP_F5_MV_FROM_INT, `FREP_OPC_OPFP}: begin
        path_sel = frep_pkg::PathDirect;
      end
      default: begin
        path_sel = frep_pkg::PathBuffer;
      end
    endcase
  end

  ////////////////////
  // Input demux
  ////////////////////

  assign entry = '{op: inp_op_i, arga: inp_arga_i, argb: inp_argb_i};

  assign buf_wr.wvalid = inp_valid_i && (path_sel == frep_pkg::PathBuffer);
  assign buf_wr.wdata  = entry;

  assign dir_valid_o = inp_valid_i && (path_sel == frep_pkg::PathDirect);
  assign dir_entry_o = entry;

  // Iteration count travels in operand a
  assign cfg_valid_o = inp_valid_i && (path_sel == frep_pkg::PathFrep);
  assign cfg_word_o  = inp_op_i;
  assign cfg_iter_o  = inp_arga_i[`FREP_ITER_WIDTH-1:0];

  // Ready comes back only from the chosen path
  always_comb begin : proc_ready
    case (path_sel)
      frep_pkg::PathDirect: inp_ready_o = dir_ready_i;
      frep_pkg::PathFrep:   inp_ready_o = cfg_ready_i;
      default:              inp_ready_o = buf_wr.wready;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/frep_issue.sv ====
// FREP issue stage
// Staggers register fields and merges sequenced and direct traffic
`timescale 1ns/1ps
`default_nettype none
`include "frep_macros.svh"

module frep_issue (
  frep_seq_if.snk                     seq,
  input  logic                        dir_valid_i,
  input  frep_pkg::buf_entry_t        dir_entry_i,
  output logic                        dir_ready_o,
  output logic [31:0]                 oup_op_o,
  output logic [`FREP_DATA_WIDTH-1:0] oup_arga_o,
  output logic [`FREP_DATA_WIDTH-1:0] oup_argb_o,
  output logic                        oup_repd_o,
  output logic                        oup_valid_o,
  input  logic                        oup_ready_i
);

  frep_pkg::insn_u seq_op;
  logic [4:0]      stg;

  assign stg = {2'b00, seq.stagger_cnt};

  // Register offsets wrap within the 32-entry file
  always_comb begin : proc_stagger
    seq_op = seq.seq_entry.op;
    if (seq.stagger_mask[0]) begin
      seq_op.regs.rd = seq.seq_entry.op.regs.rd + stg;
    end
    if (seq.stagger_mask[1]) begin
      seq_op.regs.rs1 = seq.seq_entry.op.regs.rs1 + stg;
    end
    if (seq.stagger_mask[2]) begin
      seq_op.regs.rs2 = seq.seq_entry.op.regs.rs2 + stg;
    end
    if (seq.stagger_mask[3]) begin
      seq_op.regs.rs3 = seq.seq_entry.op.regs.rs3 + stg;
    end
  end

  ////////////////////
  // Output mux
  ////////////////////

  // Direct words wait until the sequencer drains
  always_comb begin : proc_out_mux
    if (seq.busy) begin
      oup_op_o    = seq_op;
      oup_arga_o  = seq.seq_entry.arga;
      oup_argb_o  = seq.seq_entry.argb;
      oup_repd_o  = seq.seq_repd;
      oup_valid_o = seq.seq_valid;
    end else begin
      oup_op_o    = dir_entry_i.op;
      oup_arga_o  = dir_entry_i.arga;
      oup_argb_o  = dir_entry_i.argb;
      oup_repd_o  = 1'b0;
      oup_valid_o = dir_valid_i;
    end
  end

  assign seq.seq_ready = seq.busy && oup_ready_i;
  assign dir_ready_o   = !seq.busy && oup_ready_i;

endmodule

`default_nettype wire

// ==== hw/frep_loop_ctrl.sv ====
// FREP loop controller
// Holds one loop configuration and walks the buffer, repeating the body
`timescale 1ns/1ps
`default_nettype none
`include "frep_macros.svh"

module frep_loop_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  frep_buf_if.rd_ctrl                 buf_rd,
  input  logic                        cfg_valid_i,
  input  frep_pkg::insn_u             cfg_word_i,
  input  logic [`FREP_ITER_WIDTH-1:0] cfg_iter_i,
  output logic                        cfg_ready_o,
  frep_seq_if.src                     seq
);

  localparam int unsigned StepWidth = `FREP_PTR_WIDTH + 1;

  // Loop configuration
  logic                        cfg_q;
  logic [`FREP_PTR_WIDTH-1:0]  max_inst_q;
  logic [`FREP_ITER_WIDTH-1:0] max_iter_q;
  logic [2:0]                  stagger_max_q;
  logic [3:0]                  stagger_mask_q;
  logic [`FREP_PTR_WIDTH-1:0]  base_q;
  // Set when a full buffer made base equal the read pointer at capture
  logic                        wrap_q;

  // Sequencing state
  logic                        active_q;
  logic [`FREP_PTR_WIDTH-1:0]  rd_ptr_q;
  logic [`FREP_PTR_WIDTH-1:0]  inst_cnt_q;
  logic [`FREP_ITER_WIDTH-1:0] iter_cnt_q;
  logic [2:0]                  stagger_cnt_q;

  logic cfg_accept;
  logic loop_on;
  logic seq_next;
  logic last_inst;
  logic last_iter;
  logic loop_end;

  assign cfg_ready_o = !cfg_q;
  assign cfg_accept  = cfg_valid_i && !cfg_q;
  // Body starts once earlier entries have drained past the base
  assign loop_on     = active_q || (cfg_q && !wrap_q && (rd_ptr_q == base_q));
  assign seq_next    = seq.seq_valid && seq.seq_ready;
  assign last_inst   = (inst_cnt_q == max_inst_q);
  assign last_iter   = (iter_cnt_q == max_iter_q);
  assign loop_end    = loop_on && seq_next && last_inst && last_iter;

  always_ff @(posedge clk_i) begin : proc_cfg_load
    if (cfg_accept) begin
      max_inst_q     <= cfg_word_i.frep.max_inst;
      stagger_max_q  <= cfg_word_i.frep.stagger_max;
      stagger_mask_q <= cfg_word_i.frep.stagger_mask;
      max_iter_q     <= cfg_iter_i;
      base_q         <= buf_rd.wptr;
    end
  end

  ////////////////////
  // Loop state
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_loop
    if (!rst_n_i) begin
      cfg_q         <= 1'b0;
      wrap_q        <= 1'b0;
      active_q      <= 1'b0;
      rd_ptr_q      <= '0;
      inst_cnt_q    <= '0;
      iter_cnt_q    <= '0;
      stagger_cnt_q <= '0;
    end else begin
      if (cfg_accept) begin
        cfg_q  <= 1'b1;
        wrap_q <= !buf_rd.empty && (rd_ptr_q == buf_rd.wptr);
      end else if (loop_end) begin
        cfg_q <= 1'b0;
      end else if (seq_next && !loop_on) begin
        wrap_q <= 1'b0;
      end
      active_q <= loop_on && !loop_end;

      if (seq_next) begin
        if (!loop_on) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end else if (!last_inst) begin
          rd_ptr_q   <= rd_ptr_q + 1'b1;
          inst_cnt_q <= inst_cnt_q + 1'b1;
        end else if (!last_iter) begin
          // Rewind for another pass over the body
          rd_ptr_q      <= base_q;
          inst_cnt_q    <= '0;
          iter_cnt_q    <= iter_cnt_q + 1'b1;
          stagger_cnt_q <= (stagger_cnt_q == stagger_max_q) ? 3'd0 : stagger_cnt_q + 3'd1;
        end else begin
          rd_ptr_q      <= rd_ptr_q + 1'b1;
          inst_cnt_q    <= '0;
          iter_cnt_q    <= '0;
          stagger_cnt_q <= '0;
        end
      end
    end
  end

  ////////////////////
  // Buffer and issue
  ////////////////////

  // Outside a loop each issue frees its slot, a loop frees the body at the end
  assign buf_rd.raddr   = rd_ptr_q;
  assign buf_rd.advance = loop_on ? loop_end : seq_next;
  assign buf_rd.step    = loop_on ? ({1'b0, max_inst_q} + 1'b1) : StepWidth'(1);

  assign seq.seq_valid    = buf_rd.avail;
  assign seq.seq_entry    = buf_rd.rdata;
  assign seq.seq_repd     = loop_on && (iter_cnt_q != '0);
  assign seq.stagger_cnt  = stagger_cnt_q;
  assign seq.stagger_mask = loop_on ? stagger_mask_q : 4'b0000;
  assign seq.busy         = cfg_q || !buf_rd.empty;

endmodule

`default_nettype wire

// ==== hw/frep_macros.svh ====
// FREP sequencer constants
// Widths, ring buffer geometry and the opcode values used for decoding
`ifndef FREP_MACROS_SVH
`define FREP_MACROS_SVH

// Operand and iteration counter widths
`define FREP_DATA_WIDTH 32
`define FREP_ITER_WIDTH 16

// Ring buffer geometry, depth must be 2**PTR_WIDTH
`define FREP_BUF_DEPTH 16
`define FREP_PTR_WIDTH 4

// Major opcodes
`define FREP_OPC_FREP   7'h0B
`define FREP_OPC_SYSTEM 7'h73
`define FREP_OPC_OPFP   7'h53

// OP-FP funct5 codes that move data between int and float
`define FREP_F5_CMP          5'b10100
`define FREP_F5_CVT_TO_INT   5'b11000
`define FREP_F5_CVT_FROM_INT 5'b11010
// Shared by fmv.x.w and fclass
`define FREP_F5_MV_TO_INT    5'b11100
`define FREP_F5_MV_FROM_INT  5'b11110

`endif

// ==== hw/frep_pkg.sv ====
// FREP sequencer types
// Instruction word views, path selection and ring buffer entry layout
`default_nettype none
`include "frep_macros.svh"

package frep_pkg;

  // Where the decoder sends an incoming word
  typedef enum logic [1:0] {
    PathBuffer = 2'd0,
    PathDirect = 2'd1,
    PathFrep   = 2'd2
  } inst_path_e;

  // Word seen as an FREP loop configuration
  typedef struct packed {
    logic                          rsvd_top;
    logic [10-`FREP_PTR_WIDTH:0]   rsvd_hi;
    logic [`FREP_PTR_WIDTH-1:0]    max_inst;      // Body length minus one
    logic [4:0]                    rsvd_mid;
    logic [2:0]                    stagger_max;
    logic [3:0]                    stagger_mask;  // rs3, rs2, rs1, rd
    logic                          rsvd_lo;
    logic [6:0]                    opcode;
  } frep_cfg_t;

  // Same word seen as an R4-type instruction
  typedef struct packed {
    logic [4:0] rs3;     // Also funct5 on OP-FP
    logic [1:0] funct2;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } reg_fields_t;

  typedef union packed {
    frep_cfg_t   frep;
    reg_fields_t regs;
  } insn_u;

  // One ring buffer slot
  typedef struct packed {
    insn_u                       op;
    logic [`FREP_DATA_WIDTH-1:0] arga;
    logic [`FREP_DATA_WIDTH-1:0] argb;
  } buf_entry_t;

endpackage

`default_nettype wire

// ==== hw/frep_ring_buffer.sv ====
// Instruction ring buffer
// Entries stay until released in steps, any stored entry can be read
`timescale 1ns/1ps
`default_nettype none
`include "frep_macros.svh"

module frep_ring_buffer (
  input logic        clk_i,
  input logic        rst_n_i,
  frep_buf_if.wr_dst buf_wr,
  frep_buf_if.rd_mem buf_rd
);

  localparam int unsigned CntWidth = `FREP_PTR_WIDTH + 1;

  frep_pkg::buf_entry_t       mem_q [`FREP_BUF_DEPTH];
  logic [`FREP_PTR_WIDTH-1:0] wptr_q;
  logic [`FREP_PTR_WIDTH-1:0] rel_ptr_q;
  logic [`FREP_PTR_WIDTH-1:0] rd_offset;
  logic [CntWidth-1:0]        count_q;
  logic [CntWidth-1:0]        count_d;
  logic                       push;

  assign push          = buf_wr.wvalid && buf_wr.wready;
  assign buf_wr.wready = (count_q != CntWidth'(`FREP_BUF_DEPTH));
  assign buf_wr.wptr   = wptr_q;

  // Storage
  always_ff @(posedge clk_i) begin : proc_mem
    if (push) begin
      mem_q[wptr_q] <= buf_wr.wdata;
    end
  end

  // Fill level after this cycle's push and release
  always_comb begin : proc_count
    count_d = count_q;
    if (push) begin
      count_d = count_d + 1'b1;
    end
    if (buf_rd.advance) begin
      count_d = count_d - buf_rd.step;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : proc_ptrs
    if (!rst_n_i) begin
      wptr_q    <= '0;
      rel_ptr_q <= '0;
      count_q   <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      // Step of a full depth wraps back onto the same slot
      if (buf_rd.advance) begin
        rel_ptr_q <= rel_ptr_q + buf_rd.step[`FREP_PTR_WIDTH-1:0];
      end
      count_q <= count_d;
    end
  end

  // Entry is live when it lies within count slots past the release pointer
  assign rd_offset    = buf_rd.raddr - rel_ptr_q;
  assign buf_rd.avail = ({1'b0, rd_offset} < count_q);
  assign buf_rd.rdata = mem_q[buf_rd.raddr];
  assign buf_rd.empty = (count_q == '0);

endmodule

`default_nettype wire

// ==== hw/frep_seq_if.sv ====
// Sequenced instruction stream
// Loop controller to issue stage, with stagger control and busy level
`timescale 1ns/1ps
`default_nettype none

interface frep_seq_if;

  logic                 seq_valid;
  logic                 seq_ready;
  frep_pkg::buf_entry_t seq_entry;
  logic                 seq_repd;
  logic [2:0]           stagger_cnt;
  logic [3:0]           stagger_mask;
  // Loop configured or buffer holds entries
  logic                 busy;

  modport src (output seq_valid, seq_entry, seq_repd, stagger_cnt, stagger_mask, busy,
               input seq_ready);
  modport snk (input seq_valid, seq_entry, seq_repd, stagger_cnt, stagger_mask, busy,
               output seq_ready);

endinterface

`default_nettype wire

// ==== hw/frep_sequencer.sv ====
// FREP sequencer top
// Dispatch, ring buffer, loop controller and issue stage behind plain ports
`timescale 1ns/1ps
`default_nettype none
`include "frep_macros.svh"

module frep_sequencer (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [31:0]                 inp_op_i,
  input  logic [`FREP_DATA_WIDTH-1:0] inp_arga_i,
  input  logic [`FREP_DATA_WIDTH-1:0] inp_argb_i,
  input  logic                        inp_valid_i,
  output logic                        inp_ready_o,
  output logic [31:0]                 oup_op_o,
  output logic [`FREP_DATA_WIDTH-1:0] oup_arga_o,
  output logic [`FREP_DATA_WIDTH-1:0] oup_argb_o,
  output logic                        oup_repd_o,
  output logic                        oup_valid_o,
  input  logic                        oup_ready_i
);

  frep_buf_if buf_if ();
  frep_seq_if seq_if ();

  // FREP request
  logic                        cfg_valid;
  frep_pkg::insn_u             cfg_word;
  logic [`FREP_ITER_WIDTH-1:0] cfg_iter;
  logic                        cfg_ready;

  // Direct bypass
  logic                        dir_valid;
  frep_pkg::buf_entry_t        dir_entry;
  logic                        dir_ready;

  frep_dispatch i_dispatch (
    .inp_op_i    (inp_op_i),
    .inp_arga_i  (inp_arga_i),
    .inp_argb_i  (inp_argb_i),
    .inp_valid_i (inp_valid_i),
    .inp_ready_o (inp_ready_o),
    .buf_wr      (buf_if),
    .cfg_valid_o (cfg_valid),
    .cfg_word_o  (cfg_word),
    .cfg_iter_o  (cfg_iter),
    .cfg_ready_i (cfg_ready),
    .dir_valid_o (dir_valid),
    .dir_entry_o (dir_entry),
    .dir_ready_i (dir_ready)
  );

  frep_ring_buffer i_ring_buffer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .buf_wr  (buf_if),
    .buf_rd  (buf_if)
  );

  frep_loop_ctrl i_loop_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .buf_rd      (buf_if),
    .cfg_valid_i (cfg_valid),
    .cfg_word_i  (cfg_word),
    .cfg_iter_i  (cfg_iter),
    .cfg_ready_o (cfg_ready),
    .seq         (seq_if)
  );

  frep_issue i_issue (
    .seq         (seq_if),
    .dir_valid_i (dir_valid),
    .dir_entry_i (dir_entry),
    .dir_ready_o (dir_ready),
    .oup_op_o    (oup_op_o),
    .oup_arga_o  (oup_arga_o),
    .oup_argb_o  (oup_argb_o),
    .oup_repd_o  (oup_repd_o),
    .oup_valid_o (oup_valid_o),
    .oup_ready_i (oup_ready_i)
  );

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
hw/frep_pkg.sv
hw/frep_buf_if.sv
hw/frep_seq_if.sv
hw/frep_dispatch.sv
hw/frep_ring_buffer.sv
hw/frep_loop_ctrl.sv
hw/frep_issue.sv
hw/frep_sequencer.sv
verification/frep_sequencer_tb.sv

// ==== verification/frep_sequencer_tb.sv ====
// FREP sequencer testbench
// Table of input words and expected output words, applied in a loop
`timescale 1ns/1ps
`default_nettype none

module frep_sequencer_tb;

  localparam int clk_period = 4;
  localparam int num_tests  = 6;
  localparam int max_in     = 8;
  localparam int max_out    = 12;
  localparam int watchdog_ns = num_tests * 200 * clk_period;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic [31:0] inp_op_i;
  logic [31:0] inp_arga_i;
  logic [31:0] inp_argb_i;
  logic        inp_valid_i;
  logic        inp_ready_o;
  logic [31:0] oup_op_o;
  logic [31:0] oup_arga_o;
  logic [31:0] oup_argb_o;
  logic        oup_repd_o;
  logic        oup_valid_o;
  logic        oup_ready_i = 1'b1;

  // Stimulus and expected values per test
  string       test_name [num_tests];
  logic [31:0] in_op  [num_tests][max_in];
  logic [31:0] in_a   [num_tests][max_in];
  logic [31:0] in_b   [num_tests][max_in];
  int          n_in   [num_tests];
  logic [31:0] ex_op  [num_tests][max_out];
  logic [31:0] ex_a   [num_tests][max_out];
  logic [31:0] ex_b   [num_tests][max_out];
  logic        ex_repd [num_tests][max_out];
  int          n_ex   [num_tests];
  bit          rand_bp [num_tests];
  // Output must leave in the same cycle as the input transfer
  bit          same_cycle [num_tests];

  int          cur_test  = 0;
  int          test_base = 0;
  int          out_total = 0;
  int          chk_errs  = 0;
  int          stim_errs = 0;
  bit          bp_en     = 1'b0;

  frep_sequencer i_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .inp_op_i    (inp_op_i),
    .inp_arga_i  (inp_arga_i),
    .inp_argb_i  (inp_argb_i),
    .inp_valid_i (inp_valid_i),
    .inp_ready_o (inp_ready_o),
    .oup_op_o    (oup_op_o),
    .oup_arga_o  (oup_arga_o),
    .oup_argb_o  (oup_argb_o),
    .oup_repd_o  (oup_repd_o),
    .oup_valid_o (oup_valid_o),
    .oup_ready_i (oup_ready_i)
  );

  always #(clk_period / 2) clk_i = ~clk_i;

  ////////////////////
  // Word builders
  ////////////////////

  // OP-FP word, funct5 sits in the rs3 field
  function automatic logic [31:0] fp_op(input logic [4:0] f5, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [4:0] rd);
    return {f5, 2'b00, rs2, rs1, 3'b000, rd, 7'h53};
  endfunction

  // csrrw
  function automatic logic [31:0] csr_op(input logic [11:0] csr, input logic [4:0] rs1,
                                         input logic [4:0] rd);
    return {csr, rs1, 3'b001, rd, 7'h73};
  endfunction

  // FREP with body length minus one, stagger wrap value and stagger mask
  function automatic logic [31:0] frep_op(input logic [3:0] max_inst,
                                          input logic [2:0] stagger_max,
                                          input logic [3:0] stagger_mask);
    return {8'h00, max_inst, 5'b00000, stagger_max, stagger_mask, 1'b0, 7'h0B};
  endfunction

  task automatic add_input(input int t, input logic [31:0] op, input logic [31:0] a,
                           input logic [31:0] b);
    in_op[t][n_in[t]] = op;
    in_a[t][n_in[t]]  = a;
    in_b[t][n_in[t]]  = b;
    n_in[t]++;
  endtask

  task automatic add_expect(input int t, input logic [31:0] op, input logic [31:0] a,
                            input logic [31:0] b, input logic repd);
    ex_op[t][n_ex[t]]   = op;
    ex_a[t][n_ex[t]]    = a;
    ex_b[t][n_ex[t]]    = b;
    ex_repd[t][n_ex[t]] = repd;
    n_ex[t]++;
  endtask

  ////////////////////
  // Test table
  ////////////////////

  task automatic build_table();
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    for (int t = 0; t < num_tests; t++) begin
      n_in[t]       = 0;
      n_ex[t]       = 0;
      rand_bp[t]    = 1'b0;
      same_cycle[t] = 1'b0;
    end
    // CSR access and compare pass straight through
    test_name[0]  = "direct";
    same_cycle[0] = 1'b1;
    w0 = csr_op(12'h001, 5'd3, 5'd4);
    w1 = fp_op(5'b10100, 5'd2, 5'd1, 5'd5);
    add_input(0, w0, 32'h0000_00a0, 32'h0000_00b0);
    add_input(0, w1, 32'h0000_00a1, 32'h0000_00b1);
    add_expect(0, w0, 32'h0000_00a0, 32'h0000_00b0, 1'b0);
    add_expect(0, w1, 32'h0000_00a1, 32'h0000_00b1, 1'b0);
    // Three ordinary ops, each issued once
    test_name[1] = "buffered";
    w0 = fp_op(5'b00000, 5'd1, 5'd2, 5'd3);
    w1 = fp_op(5'b00001, 5'd4, 5'd5, 5'd6);
    w2 = fp_op(5'b00010, 5'd7, 5'd8, 5'd9);
    add_input(1, w0, 32'h1000_0000, 32'h2000_0000);
    add_input(1, w1, 32'h1000_0001, 32'h2000_0001);
    add_input(1, w2, 32'h1000_0002, 32'h2000_0002);
    add_expect(1, w0, 32'h1000_0000, 32'h2000_0000, 1'b0);
    add_expect(1, w1, 32'h1000_0001, 32'h2000_0001, 1'b0);
    add_expect(1, w2, 32'h1000_0002, 32'h2000_0002, 1'b0);
    // Body of 2, three passes (iteration operand is count minus one)
    test_name[2] = "repetition";
    w0 = fp_op(5'b00000, 5'd10, 5'd11, 5'd12);
    w1 = fp_op(5'b00011, 5'd13, 5'd14, 5'd15);
    add_input(2, frep_op(4'd1, 3'd0, 4'b0000), 32'd2, 32'd0);
    add_input(2, w0, 32'h3000_0000, 32'h4000_0000);
    add_input(2, w1, 32'h3000_0001, 32'h4000_0001);
    for (int p = 0; p < 3; p++) begin
      add_expect(2, w0, 32'h3000_0000, 32'h4000_0000, p != 0);
      add_expect(2, w1, 32'h3000_0001, 32'h4000_0001, p != 0);
    end
    // Stagger rd and rs1 by 0, 1, 0 with wrap at 32
    test_name[3] = "stagger";
    w0 = fp_op(5'b00001, 5'd6, 5'd7, 5'd8);
    w1 = fp_op(5'b00010, 5'd9, 5'd30, 5'd31);
    add_input(3, frep_op(4'd1, 3'd1, 4'b0011), 32'd2, 32'd0);
    add_input(3, w0, 32'h5000_0000, 32'h6000_0000);
    add_input(3, w1, 32'h5000_0001, 32'h6000_0001);
    add_expect(3, w0, 32'h5000_0000, 32'h6000_0000, 1'b0);
    add_expect(3, w1, 32'h5000_0001, 32'h6000_0001, 1'b0);
    add_expect(3, fp_op(5'b00001, 5'd6, 5'd8, 5'd9), 32'h5000_0000, 32'h6000_0000, 1'b1);
    add_expect(3, fp_op(5'b00010, 5'd9, 5'd31, 5'd0), 32'h5000_0001, 32'h6000_0001, 1'b1);
    add_expect(3, w0, 32'h5000_0000, 32'h6000_0000, 1'b1);
    add_expect(3, w1, 32'h5000_0001, 32'h6000_0001, 1'b1);
    // Direct word queued behind buffered words, random output stalls
    test_name[4] = "ordering";
    rand_bp[4]   = 1'b1;
    for (int k = 0; k < 3; k++) begin
      w0 = fp_op(5'b00000, 5'(k), 5'(k + 1), 5'(k + 2));
      add_input(4, w0, 32'h7000_0000 + k, 32'h8000_0000 + k);
      add_expect(4, w0, 32'h7000_0000 + k, 32'h8000_0000 + k, 1'b0);
    end
    w1 = csr_op(12'h003, 5'd9, 5'd10);
    add_input(4, w1, 32'h7000_00ff, 32'h8000_00ff);
    add_expect(4, w1, 32'h7000_00ff, 32'h8000_00ff, 1'b0);
    // Second FREP waits for the first loop to end
    test_name[5] = "back_to_back";
    rand_bp[5]   = 1'b1;
    w0 = fp_op(5'b00000, 5'd16, 5'd17, 5'd18);
    w1 = fp_op(5'b00001, 5'd19, 5'd20, 5'd21);
    w2 = fp_op(5'b00010, 5'd22, 5'd23, 5'd24);
    add_input(5, frep_op(4'd1, 3'd0, 4'b0000), 32'd2, 32'd0);
    add_input(5, w0, 32'h9000_0000, 32'ha000_0000);
    add_input(5, w1, 32'h9000_0001, 32'ha000_0001);
    add_input(5, frep_op(4'd1, 3'd0, 4'b0000), 32'd1, 32'd0);
    add_input(5, w2, 32'h9000_0002, 32'ha000_0002);
    add_input(5, w0, 32'h9000_0003, 32'ha000_0003);
    for (int p = 0; p < 3; p++) begin
      add_expect(5, w0, 32'h9000_0000, 32'ha000_0000, p != 0);
      add_expect(5, w1, 32'h9000_0001, 32'ha000_0001, p != 0);
    end
    for (int p = 0; p < 2; p++) begin
      add_expect(5, w2, 32'h9000_0002, 32'ha000_0002, p != 0);
      add_expect(5, w0, 32'h9000_0003, 32'ha000_0003, p != 0);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Holds the word until the DUT takes it, returns 1 ns after that edge
  task automatic send_word(input logic [31:0] op, input logic [31:0] a,
                           input logic [31:0] b);
    logic taken;
    inp_op_i    = op;
    inp_arga_i  = a;
    inp_argb_i  = b;
    inp_valid_i = 1'b1;
    do begin
      @(negedge clk_i);
      taken = inp_ready_o;
      @(posedge clk_i);
      #1;
    end while (!taken);
    inp_valid_i = 1'b0;
  endtask

  // Output ready, random only for tests that ask for stalls
  initial begin : drive_ready
    int unsigned rnd;
    // Fixed seed for the stall pattern
    rnd = $urandom(32'h6728);
    forever begin
      @(posedge clk_i);
      #1;
      rnd = $urandom;
      oup_ready_i = bp_en ? rnd[0] : 1'b1;
    end
  end

  initial begin : run_tests
    int waited;
    int errs_before;
    int failed_tests;
    failed_tests = 0;
    rst_n_i      = 1'b0;
    inp_op_i     = '0;
    inp_arga_i   = '0;
    inp_argb_i   = '0;
    inp_valid_i  = 1'b0;
    build_table();
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    for (int t = 0; t < num_tests; t++) begin
      errs_before = chk_errs + stim_errs;
      cur_test    = t;
      test_base   = out_total;
      bp_en       = rand_bp[t];
      for (int i = 0; i < n_in[t]; i++) begin
        send_word(in_op[t][i], in_a[t][i], in_b[t][i]);
      end
      // Wait for all expected outputs, then a few idle cycles for extras
      waited = 0;
      while ((out_total - test_base < n_ex[t]) && (waited < 150)) begin
        @(posedge clk_i);
        waited++;
      end
      if (out_total - test_base < n_ex[t]) begin
        $display("test %0d: only %0d of %0d outputs arrived", t, out_total - test_base,
                 n_ex[t]);
        stim_errs++;
      end
      bp_en = 1'b0;
      repeat (4) @(posedge clk_i);
      #1;
      if (chk_errs + stim_errs == errs_before) begin
        $display("test %0d %s: pass", t, test_name[t]);
      end else begin
        $display("test %0d %s: fail", t, test_name[t]);
        failed_tests++;
      end
    end
    $display("tests %0d, failed %0d, errors %0d", num_tests, failed_tests,
             chk_errs + stim_errs);
    if (chk_errs + stim_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  ////////////////////
  // Output checker
  ////////////////////

  // Sampled mid-cycle, a transfer here completes at the next rising edge
  always @(negedge clk_i) begin : check_output
    int idx;
    if (rst_n_i && oup_valid_o && oup_ready_i) begin
      idx = out_total - test_base;
      if (idx >= n_ex[cur_test]) begin
        $display("test %0d: unexpected extra output %h at %0t ns", cur_test, oup_op_o, $time);
        chk_errs++;
      end else begin
        if (oup_op_o !== ex_op[cur_test][idx]) begin
          $display("** Error at %0t ns: oup_op_o expected %h got %h", $time,
                   ex_op[cur_test][idx], oup_op_o);
          chk_errs++;
        end
        if (oup_arga_o !== ex_a[cur_test][idx]) begin
          $display("** Error at %0t ns: oup_arga_o expected %h got %h", $time,
                   ex_a[cur_test][idx], oup_arga_o);
          chk_errs++;
        end
        if (oup_argb_o !== ex_b[cur_test][idx]) begin
          $display("** Error at %0t ns: oup_argb_o expected %h got %h", $time,
                   ex_b[cur_test][idx], oup_argb_o);
          chk_errs++;
        end
        if (oup_repd_o !== ex_repd[cur_test][idx]) begin
          $display("** Error at %0t ns: oup_repd_o expected %b got %b", $time,
                   ex_repd[cur_test][idx], oup_repd_o);
          chk_errs++;
        end
        // Bypass words leave together with their input transfer
        if (same_cycle[cur_test] &&
            !(inp_valid_i && inp_ready_o && (inp_op_i === oup_op_o))) begin
          $display("test %0d: direct word did not pass through in its input cycle",
                   cur_test);
          chk_errs++;
        end
      end
      out_total++;
    end
  end

  // Watchdog
  initial begin : watchdog
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
